// File: Bender.yml
package:
  name: hsem

sources:
  - source/hsem_pkg.sv
  - source/hsem_req_if.sv
  - source/hsem_err_if.sv
  - source/hsem_reg_access.sv
  - source/hsem_sem_bank.sv
  - source/hsem_err_record.sv
  - source/hsem_top.sv
  - target: simulation
    files:
      - bench/hsem_tb.sv

// File: bench/hsem_tb.sv
// one register access per cycle from seed 80; model assumes resource n at offset 4*n from zero
`default_nettype none

module hsem_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import hsem_pkg::*;

    localparam int  NUM_OPS  = 2000;
    localparam int  CLK_NS   = 10;
    localparam time WATCHDOG = (NUM_OPS + 50) * CLK_NS * 2;

    logic                  hclk = 1'b0;
    logic                  hresetn;
    logic                  wr_en;
    logic                  rd_en;
    logic [ADDR_WIDTH-1:0] reg_addr;
    logic [DATA_WIDTH-1:0] wdata;
    logic [DATA_WIDTH-1:0] rdata;
    logic [DATA_WIDTH-1:0] semerr;

    integer                seed;
    int                    error_count;
    int                    check_count;
    logic [DATA_WIDTH-1:0] last_rdata;

    // ------------------------------
    // reference model state
    // ------------------------------
    logic                      m_lock [RES_NUM];
    logic [ID_WIDTH-1:0]       m_owner [RES_NUM];
    logic                      m_err_valid;
    logic [ID_WIDTH-1:0]       m_err_id;
    logic [RES_IDX_WIDTH-1:0]  m_err_idx;
    logic [ERR_CODE_WIDTH-1:0] m_err_code;

    hsem_top dut
    (
        .hclk     (hclk),
        .hresetn  (hresetn),
        .wr_en    (wr_en),
        .rd_en    (rd_en),
        .reg_addr (reg_addr),
        .wdata    (wdata),
        .rdata    (rdata),
        .semerr   (semerr)
    );

    always
    begin
        #(CLK_NS / 2) hclk = ~hclk;
    end

    function automatic int unsigned rand_below(int unsigned n);
        int unsigned r;
        r = $unsigned($random(seed));
        return r % n;
    endfunction

    function automatic logic is_res_addr(logic [ADDR_WIDTH-1:0] addr);
        return (addr < RES_NUM * RES_STRIDE) && (addr[1:0] == 2'b00);
    endfunction

    function automatic logic [DATA_WIDTH-1:0] model_semerr();
        logic [DATA_WIDTH-1:0] w;
        w = '0;
        if (m_err_valid)
        begin
            w[16]   = 1'b1;
            w[15:8] = m_err_id;
            w[7:3]  = {2'b00, m_err_idx};  // resource field is 5 bits wide
            w[2:0]  = m_err_code;
        end
        return w;
    endfunction

    function automatic logic [RES_NUM-1:0] model_status(logic [ID_WIDTH-1:0] id);
        logic [RES_NUM-1:0] mask;
        for (int i = 0; i < RES_NUM; i++)
        begin
            mask[i] = m_lock[i] && (m_owner[i] == id);
        end
        return mask;
    endfunction

    function automatic logic [DATA_WIDTH-1:0] model_read(logic rd, logic [ADDR_WIDTH-1:0] addr);
        logic [DATA_WIDTH-1:0]    v;
        logic [RES_IDX_WIDTH-1:0] idx;
        v   = '0;
        idx = addr[4:2];
        if (rd && is_res_addr(addr))
        begin
            v = {16'h0000, m_owner[idx], 7'b0000000, m_lock[idx]};
        end
        else if (rd)
        begin
            case (addr)
                ERR_OFFSET:      v = model_semerr();
                STATUS_0_OFFSET: v = {24'h000000, model_status(CORE_0_ID)};
                STATUS_1_OFFSET: v = {24'h000000, model_status(CORE_1_ID)};
                default:         v = '0;
            endcase
        end
        return v;
    endfunction

    task automatic model_reset();
        for (int i = 0; i < RES_NUM; i++)
        begin
            m_lock[i]  = 1'b0;
            m_owner[i] = '0;
        end
        m_err_valid = 1'b0;
        m_err_id    = '0;
        m_err_idx   = '0;
        m_err_code  = '0;
    endtask

    task automatic record_error(logic [2:0] code, logic [2:0] idx, logic [7:0] id);
        if (!m_err_valid)  // first error sticks
        begin
            m_err_valid = 1'b1;
            m_err_code  = code;
            m_err_idx   = idx;
            m_err_id    = id;
        end
    endtask

    // ------------------------------
    // lock and release rules
    // ------------------------------
    task automatic apply_write(logic [ADDR_WIDTH-1:0] addr, logic [DATA_WIDTH-1:0] data);
        logic [RES_IDX_WIDTH-1:0] idx;
        logic [ID_WIDTH-1:0]      id;
        logic                     lk;
        idx = addr[4:2];
        id  = data[15:8];
        lk  = data[0];
        if (addr == ERR_CLR_OFFSET)
        begin
            m_err_valid = 1'b0;  // a clear write carries no error of its own
        end
        else if (is_res_addr(addr) && (id != '0))
        begin
            if (lk)
            begin
                if (!m_lock[idx])
                begin
                    m_lock[idx]  = 1'b1;
                    m_owner[idx] = id;
                end
                else if (m_owner[idx] == id)
                begin
                    record_error(ERR_ALREADY_OWN, idx, id);
                end
            end
            else if (!m_lock[idx])
            begin
                record_error(ERR_ALREADY_FREE, idx, id);
            end
            else if (m_owner[idx] != id)
            begin
                record_error(ERR_ILLEGAL_FREE, idx, id);
            end
            else
            begin
                m_lock[idx]  = 1'b0;
                m_owner[idx] = '0;
            end
        end
    endtask

    task automatic check_value(string name, logic [DATA_WIDTH-1:0] exp,
                               logic [DATA_WIDTH-1:0] act);
        check_count++;
        if (act !== exp)
        begin
            error_count++;
            $display("mismatch %s: expected %08h, actual %08h", name, exp, act);
        end
    endtask

    // drive at the rising edge, check at the falling edge
    task automatic do_op(logic wr, logic rd, logic [ADDR_WIDTH-1:0] addr,
                         logic [DATA_WIDTH-1:0] data);
        logic [DATA_WIDTH-1:0] exp_rd;
        @(posedge hclk);
        wr_en    <= wr;
        rd_en    <= rd;
        reg_addr <= addr;
        wdata    <= data;
        @(negedge hclk);
        exp_rd     = model_read(rd, addr);
        last_rdata = rdata;
        check_value($sformatf("rdata addr %02h rd_en %0b", addr, rd), exp_rd, rdata);
        check_value("semerr", model_semerr(), semerr);
        if (wr)
        begin
            apply_write(addr, data);  // takes effect at the next edge
        end
    endtask

    task automatic check_reset_state();
        for (int i = 0; i < RES_NUM; i++)
        begin
            do_op(1'b0, 1'b1, ADDR_WIDTH'(RES_BASE_OFFSET + i * RES_STRIDE), '0);
            check_value($sformatf("reset resource %0d", i), '0, last_rdata);
        end
        do_op(1'b0, 1'b1, ERR_OFFSET, '0);
        check_value("reset error word", '0, last_rdata);
        do_op(1'b0, 1'b1, STATUS_0_OFFSET, '0);
        check_value("reset status 0", '0, last_rdata);
        do_op(1'b0, 1'b1, STATUS_1_OFFSET, '0);
        check_value("reset status 1", '0, last_rdata);
        check_value("reset semerr", '0, semerr);
    endtask

    function automatic logic [ADDR_WIDTH-1:0] pick_read_addr();
        logic [ADDR_WIDTH-1:0] named [6];
        int unsigned           sel;
        named = '{ERR_OFFSET, STATUS_0_OFFSET, STATUS_1_OFFSET, ERR_CLR_OFFSET, 8'h20, 8'h24};
        sel   = rand_below(3);
        if (sel == 0)
        begin
            return ADDR_WIDTH'(RES_BASE_OFFSET + rand_below(RES_NUM) * RES_STRIDE);
        end
        else if (sel == 1)
        begin
            return named[rand_below(6)];
        end
        return ADDR_WIDTH'(rand_below(256));  // holes and odd offsets too
    endfunction

    // ------------------------------
    // random operations
    // ------------------------------
    task automatic run_random();
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] data;
        logic [ID_WIDTH-1:0]   ids [4];
        logic                  pend;
        logic [ADDR_WIDTH-1:0] pend_addr;
        int unsigned           kind;
        ids       = '{8'd0, CORE_0_ID, CORE_1_ID, 8'd5};
        pend      = 1'b0;
        pend_addr = '0;
        for (int n = 0; n < NUM_OPS; n++)
        begin
            if (pend)
            begin
                do_op(1'b0, 1'b1, pend_addr, '0);  // read back the written resource
                pend = 1'b0;
            end
            else
            begin
                kind = rand_below(10);
                if (kind < 4)
                begin
                    addr       = ADDR_WIDTH'(RES_BASE_OFFSET + rand_below(RES_NUM) * RES_STRIDE);
                    data       = $random(seed);
                    data[15:8] = ids[rand_below(4)];
                    do_op(1'b1, 1'b0, addr, data);
                    pend      = 1'b1;
                    pend_addr = addr;
                end
                else if (kind < 7)
                begin
                    do_op(1'b0, 1'b1, pick_read_addr(), '0);
                end
                else if (kind == 7)
                begin
                    do_op(1'b1, 1'b0, ERR_CLR_OFFSET, $random(seed));
                end
                else
                begin
                    do_op(1'b0, 1'b0, ADDR_WIDTH'(rand_below(256)), $random(seed));  // idle
                end
            end
        end
    endtask

    initial
    begin
        seed        = 80;
        error_count = 0;
        check_count = 0;
        last_rdata  = '0;
        hresetn  <= 1'b0;
        wr_en    <= 1'b0;
        rd_en    <= 1'b0;
        reg_addr <= '0;
        wdata    <= '0;
        model_reset();
        repeat (3) @(posedge hclk);
        hresetn <= 1'b1;
        check_reset_state();
        run_random();
        do_op(1'b0, 1'b0, '0, '0);  // lets the last write settle
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
        begin
            $display("All checks passed");
        end
        else
        begin
            $display("Checks failed");
        end
        $finish;
    end

    // ------------------------------
    // watchdog
    // ------------------------------
    initial
    begin
        #(WATCHDOG);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
source/hsem_pkg.sv
source/hsem_req_if.sv
source/hsem_err_if.sv
source/hsem_reg_access.sv
source/hsem_sem_bank.sv
source/hsem_err_record.sv
source/hsem_top.sv
bench/hsem_tb.sv

// File: source/hsem_err_if.sv
// one error event per cycle, same strobe rule as the request, nothing can stall it
`default_nettype none

interface hsem_err_if;
    import hsem_pkg::*;

    logic                     valid;  // single-cycle strobe
    err_code_t                code;
    logic [RES_IDX_WIDTH-1:0] index;  // offending resource
    logic [ID_WIDTH-1:0]      id;     // writer that caused it

    modport src
    (
        output valid, code, index, id
    );

    modport dst
    (
        input valid, code, index, id
    );

endinterface

`default_nettype wire

// File: source/hsem_err_record.sv
// keeps only the first error until software clears it; later errors are lost
`default_nettype none

module hsem_err_record
(
    input  logic                            hclk,
    input  logic                            hresetn,
    hsem_err_if.dst                         err,
    input  logic                            err_clear,
    output logic [hsem_pkg::DATA_WIDTH-1:0] semerr
);
    import hsem_pkg::*;

    logic                     valid_q;
    err_code_t                code_q;
    logic [RES_IDX_WIDTH-1:0] index_q;
    logic [ID_WIDTH-1:0]      id_q;
    logic                     capture;

    // new error wins over a clear in the same cycle
    assign capture = err.valid && (!valid_q || err_clear);

    always_ff @(posedge hclk or negedge hresetn)
    begin
        if (!hresetn)
        begin
            valid_q <= 1'b0;
        end
        else if (capture)
        begin
            valid_q <= 1'b1;
        end
        else if (err_clear)
        begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge hclk)
    begin
        if (capture)
        begin
            code_q  <= err.code;
            index_q <= err.index;
            id_q    <= err.id;
        end
    end

    // ------------------------------
    // semerr packing
    // ------------------------------
    assign semerr = valid_q ? {{(DATA_WIDTH-SEMERR_VALID_BIT-1){1'b0}}, 1'b1, id_q,
                               {(SEMNUM_WIDTH-RES_IDX_WIDTH){1'b0}}, index_q, code_q}
                            : '0;  // whole word zero when nothing held

    a_code_legal: assert property (@(posedge hclk) disable iff (!hresetn)
        valid_q |-> (code_q inside {ERR_ALREADY_FREE, ERR_ILLEGAL_FREE, ERR_ALREADY_OWN}))
        else $error("stored error code %0d is undefined", code_q);

endmodule

`default_nettype wire

// File: source/hsem_pkg.sv
// two cores only (ids 1 and 2), eight resources, fixed 8-bit word-aligned register map
`default_nettype none

package hsem_pkg;

    // ------------------------------
    // bus and array sizes
    // ------------------------------
    localparam int DATA_WIDTH    = 32;
    localparam int ADDR_WIDTH    = 8;
    localparam int RES_NUM       = 8;
    localparam int RES_IDX_WIDTH = 3;
    localparam int ID_WIDTH      = 8;
    localparam int SEM_WIDTH     = 16;  // one semaphore word
    localparam int SEMNUM_WIDTH  = 5;   // resource field in semerr

    // known owners, zero means nobody
    localparam logic [ID_WIDTH-1:0] CORE_0_ID = 8'd1;
    localparam logic [ID_WIDTH-1:0] CORE_1_ID = 8'd2;

    // ------------------------------
    // register map
    // ------------------------------
    localparam logic [ADDR_WIDTH-1:0] RES_BASE_OFFSET = 8'h00;
    localparam int                    RES_STRIDE      = 4;
    localparam logic [ADDR_WIDTH-1:0] RES_END_OFFSET  =
        ADDR_WIDTH'(RES_BASE_OFFSET + RES_NUM * RES_STRIDE);  // first offset past the bank

    // 0x20 and 0x24 are unused and read as zero
    localparam logic [ADDR_WIDTH-1:0] ERR_OFFSET      = 8'h28;
    localparam logic [ADDR_WIDTH-1:0] ERR_CLR_OFFSET  = 8'h2C;
    localparam logic [ADDR_WIDTH-1:0] STATUS_0_OFFSET = 8'h30;
    localparam logic [ADDR_WIDTH-1:0] STATUS_1_OFFSET = 8'h34;

    // ------------------------------
    // error codes
    // ------------------------------
    localparam int ERR_CODE_WIDTH = 3;

    typedef enum logic [ERR_CODE_WIDTH-1:0] {
        ERR_ALREADY_FREE = 3'd0,  // release of a free resource
        ERR_ILLEGAL_FREE = 3'd1,  // release of another core's resource
        ERR_ALREADY_OWN  = 3'd3   // lock of a resource already held
    } err_code_t;

    // valid flag sits just above id, number and code
    localparam int SEMERR_VALID_BIT = ID_WIDTH + SEMNUM_WIDTH + ERR_CODE_WIDTH;

    // ------------------------------
    // semaphore word
    // ------------------------------
    // same layout as the write data: id in 15..8, lock request in bit 0
    typedef struct packed {
        logic [ID_WIDTH-1:0]             owner;
        logic [SEM_WIDTH-ID_WIDTH-2:0]   rsvd;   // always zero
        logic                            lock;   // set means taken
    } sem_word_t;

    typedef sem_word_t [RES_NUM-1:0] sem_array_t;

endpackage

`default_nettype wire

// File: source/hsem_reg_access.sv
// purely combinational; rdata is zero for rd_en low, unmapped or non-aligned offsets
`default_nettype none

module hsem_reg_access
(
    input  logic                            wr_en,
    input  logic                            rd_en,
    input  logic [hsem_pkg::ADDR_WIDTH-1:0] reg_addr,
    input  logic [hsem_pkg::DATA_WIDTH-1:0] wdata,
    input  hsem_pkg::sem_array_t            sem_words,
    input  logic [hsem_pkg::RES_NUM-1:0]    status_0,
    input  logic [hsem_pkg::RES_NUM-1:0]    status_1,
    input  logic [hsem_pkg::DATA_WIDTH-1:0] semerr,
    hsem_req_if.src                         req,
    output logic                            err_clear,
    output logic [hsem_pkg::DATA_WIDTH-1:0] rdata
);
    import hsem_pkg::*;

    logic [ADDR_WIDTH-1:0]    res_off;
    logic [ADDR_WIDTH-1:0]    res_slot;
    logic [RES_IDX_WIDTH-1:0] res_idx;
    logic                     res_hit;
    sem_word_t                wr_word;

    // ------------------------------
    // address decode
    // ------------------------------
    assign res_off  = reg_addr - RES_BASE_OFFSET;
    assign res_slot = ADDR_WIDTH'(res_off / RES_STRIDE);
    assign res_idx  = res_slot[RES_IDX_WIDTH-1:0];
    assign res_hit  = (reg_addr >= RES_BASE_OFFSET) && (reg_addr < RES_END_OFFSET)
                   && ((res_off % RES_STRIDE) == 0);  // word aligned only

    // write data shares the semaphore word layout
    assign wr_word = sem_word_t'(wdata[SEM_WIDTH-1:0]);

    // ------------------------------
    // write side
    // ------------------------------
    assign req.valid = wr_en && res_hit && (wr_word.owner != '0);  // id zero is no owner
    assign req.index = res_idx;
    assign req.lock  = wr_word.lock;
    assign req.id    = wr_word.owner;

    assign err_clear = wr_en && (reg_addr == ERR_CLR_OFFSET);

    // ------------------------------
    // read mux
    // ------------------------------
    always_comb
    begin
        rdata = '0;
        if (rd_en)
        begin
            if (res_hit)
            begin
                rdata = {{(DATA_WIDTH-SEM_WIDTH){1'b0}}, sem_words[res_idx]};
            end
            else
            begin
                case (reg_addr)
                    ERR_OFFSET:      rdata = semerr;
                    STATUS_0_OFFSET: rdata = {{(DATA_WIDTH-RES_NUM){1'b0}}, status_0};
                    STATUS_1_OFFSET: rdata = {{(DATA_WIDTH-RES_NUM){1'b0}}, status_1};
                    default:         rdata = '0;  // clear offset and holes
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: source/hsem_req_if.sv
// one decoded semaphore write per cycle, no back-pressure since the bank always accepts
`default_nettype none

interface hsem_req_if;
    import hsem_pkg::*;

    logic                     valid;  // single-cycle strobe
    logic [RES_IDX_WIDTH-1:0] index;
    logic                     lock;   // 1 lock, 0 release
    logic [ID_WIDTH-1:0]      id;     // never zero while valid

    modport src
    (
        output valid, index, lock, id
    );

    modport dst
    (
        input valid, index, lock, id
    );

endinterface

`default_nettype wire

// File: source/hsem_sem_bank.sv
// one request per cycle; lock on a resource held by the other core is dropped with no error
`default_nettype none

module hsem_sem_bank
(
    input  logic                         hclk,
    input  logic                         hresetn,
    hsem_req_if.dst                      req,
    hsem_err_if.src                      err,
    output hsem_pkg::sem_array_t         sem_words,
    output logic [hsem_pkg::RES_NUM-1:0] status_0,
    output logic [hsem_pkg::RES_NUM-1:0] status_1
);
    import hsem_pkg::*;

    sem_array_t sem_q;
    sem_word_t  cur;       // addressed semaphore
    logic       take;
    logic       drop;
    logic       err_hit;
    err_code_t  err_code;

    assign cur = sem_q[req.index];

    // ------------------------------
    // lock and release rules
    // ------------------------------
    always_comb
    begin
        take     = 1'b0;
        drop     = 1'b0;
        err_hit  = 1'b0;
        err_code = ERR_ALREADY_FREE;
        if (req.valid)
        begin
            if (req.lock)
            begin
                if (!cur.lock)
                begin
                    take = 1'b1;
                end
                else if (cur.owner == req.id)
                begin
                    err_hit  = 1'b1;
                    err_code = ERR_ALREADY_OWN;
                end
                // held by someone else, quietly denied
            end
            else if (!cur.lock)
            begin
                err_hit  = 1'b1;
                err_code = ERR_ALREADY_FREE;
            end
            else if (cur.owner != req.id)
            begin
                err_hit  = 1'b1;
                err_code = ERR_ILLEGAL_FREE;
            end
            else
            begin
                drop = 1'b1;  // owner gives it back
            end
        end
    end

    always_ff @(posedge hclk or negedge hresetn)
    begin
        if (!hresetn)
        begin
            sem_q <= '0;
        end
        else if (take)
        begin
            sem_q[req.index] <= '{owner: req.id, rsvd: '0, lock: 1'b1};
        end
        else if (drop)
        begin
            sem_q[req.index] <= '0;  // free and owner back to zero
        end
    end

    // error event goes out in the request cycle
    assign err.valid = err_hit;
    assign err.code  = err_code;
    assign err.index = req.index;
    assign err.id    = req.id;

    assign sem_words = sem_q;

    // ------------------------------
    // per-core ownership
    // ------------------------------
    for (genvar i = 0; i < RES_NUM; i++)
    begin : g_res
        assign status_0[i] = (sem_q[i].owner == CORE_0_ID);
        assign status_1[i] = (sem_q[i].owner == CORE_1_ID);

        a_free_no_owner: assert property (@(posedge hclk) disable iff (!hresetn)
            !sem_q[i].lock |-> (sem_q[i].owner == '0))
            else $error("free semaphore %0d keeps an owner", i);
    end

    // a faulty write comes with a request and leaves every semaphore as it was
    a_err_needs_req: assert property (@(posedge hclk) disable iff (!hresetn)
        err.valid |-> req.valid ##1 (sem_q == $past(sem_q)))
        else $error("error event without a request or with a semaphore change");

    a_single_owner: assert property (@(posedge hclk) disable iff (!hresetn)
        (status_0 & status_1) == '0)
        else $error("resource marked for both cores");

endmodule

`default_nettype wire

// File: source/hsem_top.sv
// plain strobe port, no AHB wrapper; interrupt offsets 0x20 and 0x24 read as zero
`default_nettype none

module hsem_top
(
    input  logic                            hclk,
    input  logic                            hresetn,
    input  logic                            wr_en,
    input  logic                            rd_en,
    input  logic [hsem_pkg::ADDR_WIDTH-1:0] reg_addr,
    input  logic [hsem_pkg::DATA_WIDTH-1:0] wdata,
    output logic [hsem_pkg::DATA_WIDTH-1:0] rdata,
    output logic [hsem_pkg::DATA_WIDTH-1:0] semerr
);
    import hsem_pkg::*;

    sem_array_t           sem_words;
    logic [RES_NUM-1:0]   status_0;
    logic [RES_NUM-1:0]   status_1;
    logic                 err_clear;

    hsem_req_if req_if ();
    hsem_err_if err_if ();

    // ------------------------------
    // decode and read mux
    // ------------------------------
    hsem_reg_access u_reg_access
    (
        .wr_en     (wr_en),
        .rd_en     (rd_en),
        .reg_addr  (reg_addr),
        .wdata     (wdata),
        .sem_words (sem_words),
        .status_0  (status_0),
        .status_1  (status_1),
        .semerr    (semerr),
        .req       (req_if.src),
        .err_clear (err_clear),
        .rdata     (rdata)
    );

    hsem_sem_bank u_sem_bank
    (
        .hclk      (hclk),
        .hresetn   (hresetn),
        .req       (req_if.dst),
        .err       (err_if.src),
        .sem_words (sem_words),
        .status_0  (status_0),
        .status_1  (status_1)
    );

    hsem_err_record u_err_record
    (
        .hclk      (hclk),
        .hresetn   (hresetn),
        .err       (err_if.dst),
        .err_clear (err_clear),
        .semerr    (semerr)  // also read back at ERR_OFFSET
    );

endmodule

`default_nettype wire
